//--- testbench/soc_cases.txt
# name op address wdata key exp_rdata exp_error (hex fields)
# op: W write, R read, B write with a second start pulse while busy
ram_wr_a     W 00000010 cafef00d 0 00000000 0
ram_rd_a     R 00000010 00000000 0 cafef00d 0
ram_wr_b     W 00000014 12345678 0 00000000 0
ram_rd_a2    R 00000010 00000000 0 cafef00d 0
ram_rd_b     R 00000014 00000000 0 12345678 0
ram_wr_top   W 000003fc a5a55a5a 0 00000000 0
ram_rd_top   R 000003fc 00000000 0 a5a55a5a 0
led_wr       W 50000000 fffff2b7 0 00000000 0
led_rd       R 50000000 00000000 0 000002b7 0
key_rd_9     R 50000004 00000000 9 00000009 0
key_rd_6     R 50000004 00000000 6 00000006 0
io_unused_rd R 50000008 00000000 3 00000000 0
key_wr       W 50000004 0000000f 3 00000000 0
key_rd_3     R 50000004 00000000 3 00000003 0
unmap_rd     R 60000000 00000000 0 00000000 1
ram_after_rd R 00000010 00000000 0 cafef00d 0
unmap_wr     W 00000400 deadbeef 0 00000000 1
ram_after_wr W 00000020 0badc0de 0 00000000 0
ram_rd_20    R 00000020 00000000 0 0badc0de 0
busy_wr      B 00000030 13572468 0 00000000 0
busy_rd      R 00000030 00000000 0 13572468 0
led_rd_hold  R 50000000 00000000 0 000002b7 0

//--- files.f
+incdir+logic
logic/bus_pkg.sv
logic/board_pkg.sv
logic/bus_if.sv
logic/bus_controller.sv
logic/bus_decoder.sv
logic/block_ram.sv
logic/io_port.sv
logic/soc_top.sv
testbench/soc_asserts.sv
testbench/soc_tb.sv

//--- Bender.yml
package:
  name: soc_bus

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/bus_pkg.sv
      - logic/board_pkg.sv
      - logic/bus_if.sv
      - logic/bus_controller.sv
      - logic/bus_decoder.sv
      - logic/block_ram.sv
      - logic/io_port.sv
      - logic/soc_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/soc_asserts.sv
      - testbench/soc_tb.sv

//--- testbench/soc_tb.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_tb
	import bus_pkg::*, board_pkg::*;
();

	localparam int DONE_LIMIT = 64;

	logic clock;
	logic i_rst;
	logic i_cmd_start;
	logic i_cmd_rw;
	addr_t i_cmd_address;
	data_t i_cmd_wdata;
	key_t i_key;
	logic o_busy;
	logic o_done;
	logic o_error;
	data_t o_rdata;
	led_t o_led;

	int pass_count;
	int fail_count;
	bit hung;
	integer seed;

	// Expected RAM contents for the random test
	data_t model [`SOC_RAM_WORDS];

	soc_top dut (
		.clock(clock),
		.i_rst(i_rst),
		.i_cmd_start(i_cmd_start),
		.i_cmd_rw(i_cmd_rw),
		.i_cmd_address(i_cmd_address),
		.i_cmd_wdata(i_cmd_wdata),
		.o_busy(o_busy),
		.o_done(o_done),
		.o_rdata(o_rdata),
		.o_error(o_error),
		.i_key(i_key),
		.o_led(o_led)
	);

	always #20 clock = ~clock;

	// Issues one command and waits for o_done
	// With overlap set, a second start pulse arrives while busy
	task automatic issue_cmd(input logic rw, input addr_t address, input data_t wdata,
		input bit overlap, output bit finished, output bit busy_ok);
		int cycles;
		@(posedge clock);
		i_cmd_start <= 1'b1;
		i_cmd_rw <= rw;
		i_cmd_address <= address;
		i_cmd_wdata <= wdata;
		@(posedge clock);
		i_cmd_start <= 1'b0;
		if (overlap)
		begin
			@(posedge clock);
			i_cmd_start <= 1'b1;
			i_cmd_wdata <= ~wdata;
			@(posedge clock);
			i_cmd_start <= 1'b0;
		end
		finished = 1'b0;
		busy_ok = 1'b1;
		cycles = 0;
		while (!finished && cycles < DONE_LIMIT)
		begin
			@(negedge clock);
			// o_busy covers the command and drops as o_done pulses
			if (o_done)
			begin
				finished = 1'b1;
				if (o_busy !== 1'b0)
					busy_ok = 1'b0;
			end
			else if (o_busy !== 1'b1)
				busy_ok = 1'b0;
			cycles++;
		end
	endtask

	task automatic run_case(input string name, input string op, input addr_t address,
		input data_t wdata, input key_t key, input data_t exp_rdata, input logic exp_error);
		bit finished;
		bit busy_ok;
		bit ok;
		bit is_write;
		int extra_done;
		ok = 1'b1;
		is_write = (op != "R");
		// Keys settle through the synchronizer before the access
		@(posedge clock);
		i_key <= key;
		repeat (3) @(posedge clock);
		issue_cmd(is_write, address, wdata, op == "B", finished, busy_ok);
		if (!finished)
		begin
			$display("%s: o_done did not arrive within %0d cycles", name, DONE_LIMIT);
			hung = 1'b1;
			fail_count++;
			return;
		end
		if (!busy_ok)
		begin
			$display("%s: o_busy was not high until o_done or stayed high with it", name);
			ok = 1'b0;
		end
		if (o_error !== exp_error)
		begin
			$display("CHECK FAILED %s o_error expected %b actual %b", name, exp_error, o_error);
			ok = 1'b0;
		end
		if ((!is_write || exp_error) && o_rdata !== exp_rdata)
		begin
			$display("CHECK FAILED %s o_rdata expected %h actual %h", name, exp_rdata, o_rdata);
			ok = 1'b0;
		end
		if (is_write && !exp_error && address == `SOC_IO_BASE
			&& o_led !== wdata[`SOC_LED_W-1:0])
		begin
			$display("CHECK FAILED %s o_led expected %h actual %h", name,
				wdata[`SOC_LED_W-1:0], o_led);
			ok = 1'b0;
		end
		if (op == "B")
		begin
			extra_done = 0;
			repeat (8)
			begin
				@(negedge clock);
				if (o_done)
					extra_done++;
			end
			if (extra_done != 0)
			begin
				$display("%s: start pulse during busy gave %0d extra o_done", name, extra_done);
				ok = 1'b0;
			end
		end
		if (ok)
			pass_count++;
		else
			fail_count++;
		$display("%-14s %s", name, ok ? "ok" : "bad");
	endtask

	// Random words into random RAM locations and a read-back of each
	task automatic run_random(input int count);
		addr_t addrs [$];
		addr_t address;
		data_t wdata;
		bit finished;
		bit busy_ok;
		bit ok;
		int i;
		ok = 1'b1;
		for (i = 0; i < count && !hung; i++)
		begin
			address = addr_t'($unsigned($random(seed)) % `SOC_RAM_WORDS) << 2;
			wdata = $random(seed);
			issue_cmd(1'b1, address, wdata, 1'b0, finished, busy_ok);
			hung = !finished;
			if (finished && !busy_ok)
			begin
				$display("random_ram[%0d]: o_busy did not track the write", i);
				ok = 1'b0;
			end
			model[address[$clog2(`SOC_RAM_WORDS)+1:2]] = wdata;
			addrs.push_back(address);
		end
		for (i = 0; i < addrs.size() && !hung; i++)
		begin
			address = addrs[i];
			issue_cmd(1'b0, address, '0, 1'b0, finished, busy_ok);
			hung = !finished;
			if (finished && !busy_ok)
			begin
				$display("random_ram[%0d]: o_busy did not track the read", i);
				ok = 1'b0;
			end
			if (finished && o_rdata !== model[address[$clog2(`SOC_RAM_WORDS)+1:2]])
			begin
				$display("CHECK FAILED random_ram[%0d] o_rdata expected %h actual %h", i,
					model[address[$clog2(`SOC_RAM_WORDS)+1:2]], o_rdata);
				ok = 1'b0;
			end
		end
		if (ok && !hung)
			pass_count++;
		else
			fail_count++;
		$display("%-14s %s", "random_ram", (ok && !hung) ? "ok" : "bad");
	endtask

	initial
	begin
		int fd;
		string line;
		string name;
		string op;
		addr_t address;
		data_t wdata;
		data_t exp_rdata;
		key_t key;
		logic exp_error;
		clock = 1'b0;
		i_rst = 1'b1;
		i_cmd_start = 1'b0;
		i_cmd_rw = 1'b0;
		i_cmd_address = '0;
		i_cmd_wdata = '0;
		i_key = '0;
		pass_count = 0;
		fail_count = 0;
		hung = 1'b0;
		seed = 31362;
		repeat (2) @(posedge clock);
		i_rst <= 1'b0;
		@(negedge clock);
		if (o_busy !== 1'b0 || o_done !== 1'b0 || o_error !== 1'b0 || o_led !== '0)
		begin
			$display("Outputs not idle after reset");
			fail_count++;
		end
		fd = $fopen("testbench/soc_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open testbench/soc_cases.txt");
			fail_count++;
		end
		else
		begin
			while (!hung && !$feof(fd))
			begin
				if ($fgets(line, fd) > 0 && line.substr(0, 0) != "#")
				begin
					if ($sscanf(line, "%s %s %h %h %h %h %h", name, op, address, wdata,
						key, exp_rdata, exp_error) == 7)
						run_case(name, op, address, wdata, key, exp_rdata, exp_error);
				end
			end
			$fclose(fd);
		end
		if (!hung)
			run_random(12);
		if (hung)
			$display("Run stopped early, a command never completed");
		$display("Summary: %0d tests ok, %0d failed", pass_count, fail_count);
		if (hung || fail_count != 0)
			$display("SIMULATION FAILED");
		else
			$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- testbench/soc_asserts.sv
`timescale 1ns/1ps

module soc_asserts
	import bus_pkg::*;
(
	input logic clock,
	input logic i_rst,
	input logic request,
	input logic ready,
	input addr_t address,
	input logic o_busy,
	input logic o_done,
	input logic o_error
);

	// Request holds with a stable address until ready, or the fault is flagged
	assert property (@(posedge clock) disable iff (i_rst)
		request && !ready |=> $stable(address) && (request || o_error))
		else $error("bus request or address changed before ready or fault");

	assert property (@(posedge clock) disable iff (i_rst)
		o_done |=> !o_done)
		else $error("o_done lasted more than one cycle");

	// Idle straight out of reset
	assert property (@(posedge clock)
		i_rst |=> !o_busy && !o_done && !request)
		else $error("controller not idle after reset");

endmodule

bind bus_controller soc_asserts u_asserts (
	.clock(clock),
	.i_rst(i_rst),
	.request(bus.request),
	.ready(bus.ready),
	.address(bus.address),
	.o_busy(o_busy),
	.o_done(o_done),
	.o_error(o_error)
);

//--- logic/soc_top.sv
`timescale 1ns/1ps

module soc_top
	import bus_pkg::*, board_pkg::*;
(
	input logic clock,
	input logic i_rst,

	// Command port
	input logic i_cmd_start,
	input logic i_cmd_rw,
	input addr_t i_cmd_address,
	input data_t i_cmd_wdata,

	// Response
	output logic o_busy,
	output logic o_done,
	output data_t o_rdata,
	output logic o_error,

	// Board I/O
	input key_t i_key,
	output led_t o_led
);

	bus_if host_bus();
	bus_if ram_bus();
	bus_if io_bus();

	bus_controller u_controller (
		.clock(clock),
		.i_rst(i_rst),
		.i_cmd_start(i_cmd_start),
		.i_cmd_rw(i_cmd_rw),
		.i_cmd_address(i_cmd_address),
		.i_cmd_wdata(i_cmd_wdata),
		.bus(host_bus),
		.o_busy(o_busy),
		.o_done(o_done),
		.o_error(o_error),
		.o_rdata(o_rdata)
	);

	bus_decoder u_decoder (
		.host(host_bus),
		.ram_bus(ram_bus),
		.io_bus(io_bus)
	);

	block_ram u_ram (
		.clock(clock),
		.bus(ram_bus)
	);

	io_port u_io (
		.clock(clock),
		.i_rst(i_rst),
		.i_key(i_key),
		.o_led(o_led),
		.bus(io_bus)
	);

endmodule

//--- logic/io_port.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module io_port
	import bus_pkg::*, board_pkg::*;
(
	input logic clock,
	input logic i_rst,
	input key_t i_key,
	output led_t o_led,
	bus_if.slave bus
);

	io_reg_t offset;
	logic access;
	key_t key_meta;
	key_t key_sync;

	assign offset = io_reg_t'(bus.address[$clog2(`SOC_IO_SIZE)-1:0]);
	assign access = bus.request && !bus.ready;

	// Two-stage key synchronizer
	always_ff @(posedge clock)
	begin
		key_meta <= i_key;
		key_sync <= key_meta;
	end

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			o_led <= '0;
			bus.ready <= 1'b0;
		end
		else
		begin
			bus.ready <= access;
			if (access && bus.rw && offset == IO_REG_LED)
				o_led <= bus.wdata[`SOC_LED_W-1:0];
		end
	end

	// Read mux, writes and unused offsets give zero
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			if (!bus.rw && offset == IO_REG_LED)
				bus.rdata <= data_t'(o_led);
			else if (!bus.rw && offset == IO_REG_KEY)
				bus.rdata <= data_t'(key_sync);
			else
				bus.rdata <= '0;
		end
	end

endmodule

//--- logic/block_ram.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module block_ram
	import bus_pkg::*;
(
	input logic clock,
	bus_if.slave bus
);

	localparam int RAM_AW = $clog2(`SOC_RAM_WORDS);

	data_t mem [`SOC_RAM_WORDS];
	logic [RAM_AW-1:0] word_index;
	logic access;

	// Byte address in, word index out
	assign word_index = bus.address[RAM_AW+1:2];

	// One access per request, the held request is ignored while ready is up
	assign access = bus.request && !bus.ready;

	always_ff @(posedge clock)
	begin
		if (access && bus.rw)
			mem[word_index] <= bus.wdata;
	end

	always_ff @(posedge clock)
	begin
		if (access && !bus.rw)
			bus.rdata <= mem[word_index];
	end

	// Ready clears itself once request drops
	always_ff @(posedge clock)
	begin
		bus.ready <= access;
	end

endmodule

//--- logic/bus_decoder.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_decoder
	import bus_pkg::*;
(
	bus_if.slave host,
	bus_if.master ram_bus,
	bus_if.master io_bus
);

	localparam addr_t RAM_BASE = `SOC_RAM_BASE;
	localparam addr_t RAM_END = addr_t'(`SOC_RAM_BASE + (`SOC_RAM_WORDS * 4));
	localparam addr_t IO_BASE = `SOC_IO_BASE;
	localparam addr_t IO_END = addr_t'(`SOC_IO_BASE + `SOC_IO_SIZE);

	region_t region;

	always_comb
	begin
		if (host.address >= RAM_BASE && host.address < RAM_END)
			region = REGION_RAM;
		else if (host.address >= IO_BASE && host.address < IO_END)
			region = REGION_IO;
		else
			region = REGION_NONE;
	end

	// RAM side
	assign ram_bus.request = host.request && (region == REGION_RAM);
	assign ram_bus.rw = host.rw;
	assign ram_bus.address = host.address - RAM_BASE;
	assign ram_bus.wdata = host.wdata;

	// I/O side
	assign io_bus.request = host.request && (region == REGION_IO);
	assign io_bus.rw = host.rw;
	assign io_bus.address = host.address - IO_BASE;
	assign io_bus.wdata = host.wdata;

	// Unmapped addresses never get ready, the controller times out
	always_comb
	begin
		case (region)
			REGION_RAM:
			begin
				host.rdata = ram_bus.rdata;
				host.ready = ram_bus.ready;
			end
			REGION_IO:
			begin
				host.rdata = io_bus.rdata;
				host.ready = io_bus.ready;
			end
			default:
			begin
				host.rdata = '0;
				host.ready = 1'b0;
			end
		endcase
	end

endmodule

//--- logic/bus_controller.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_controller
	import bus_pkg::*;
(
	input logic clock,
	input logic i_rst,

	input logic i_cmd_start,
	input logic i_cmd_rw,
	input addr_t i_cmd_address,
	input data_t i_cmd_wdata,

	bus_if.master bus,

	output logic o_busy,
	output logic o_done,
	output logic o_error,
	output data_t o_rdata
);

	localparam int TIMER_W = $clog2(`SOC_BUS_TIMEOUT + 1);
	localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`SOC_BUS_TIMEOUT - 1);

	ctrl_state_t state;
	logic [TIMER_W-1:0] timer;

	// Command held for the whole transaction
	logic cmd_rw;
	addr_t cmd_address;
	data_t cmd_wdata;

	always_ff @(posedge clock)
	begin
		if (state == ST_IDLE && i_cmd_start)
		begin
			cmd_rw <= i_cmd_rw;
			cmd_address <= i_cmd_address;
			cmd_wdata <= i_cmd_wdata;
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_rst)
		begin
			state <= ST_IDLE;
			timer <= '0;
			o_done <= 1'b0;
			o_error <= 1'b0;
			o_rdata <= '0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					// Starts while busy never reach this state
					if (i_cmd_start)
					begin
						state <= ST_ACCESS;
						timer <= '0;
					end
				end
				ST_ACCESS:
				begin
					if (bus.ready)
					begin
						state <= ST_RESPOND;
						o_error <= 1'b0;
						if (!cmd_rw)
							o_rdata <= bus.rdata;
					end
					else if (timer == TIMER_LAST)
					begin
						// No slave answered
						state <= ST_RESPOND;
						o_error <= 1'b1;
						o_rdata <= '0;
					end
					else
						timer <= timer + 1'b1;
				end
				ST_RESPOND:
				begin
					o_done <= 1'b1;
					state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	assign o_busy = (state != ST_IDLE);

	// Request is a level for the whole access phase
	assign bus.request = (state == ST_ACCESS);
	assign bus.rw = cmd_rw;
	assign bus.address = cmd_address;
	assign bus.wdata = cmd_wdata;

endmodule

//--- logic/bus_if.sv
`timescale 1ns/1ps

interface bus_if
	import bus_pkg::*;
();

	logic request;
	logic rw;
	addr_t address;
	data_t wdata;
	data_t rdata;
	logic ready;

	modport master
	(
		output request, rw, address, wdata,
		input rdata, ready
	);

	modport slave
	(
		input request, rw, address, wdata,
		output rdata, ready
	);

endinterface

//--- logic/board_pkg.sv
`include "soc_settings.svh"

package board_pkg;

	typedef logic [`SOC_LED_W-1:0] led_t;
	typedef logic [`SOC_KEY_W-1:0] key_t;

	// Byte offsets inside the I/O region
	typedef enum logic [$clog2(`SOC_IO_SIZE)-1:0]
	{
		IO_REG_LED = 'h0,
		IO_REG_KEY = 'h4
	} io_reg_t;

endpackage

//--- logic/bus_pkg.sv
`include "soc_settings.svh"

package bus_pkg;

	typedef logic [`SOC_ADDR_W-1:0] addr_t;
	typedef logic [`SOC_DATA_W-1:0] data_t;

	// Slave addressed by the current bus cycle
	typedef enum logic [1:0]
	{
		REGION_NONE,
		REGION_RAM,
		REGION_IO
	} region_t;

	// Bus controller FSM
	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_ACCESS,
		ST_RESPOND
	} ctrl_state_t;

endpackage

//--- logic/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 32

// Address map
`define SOC_RAM_BASE 32'h0000_0000
`define SOC_RAM_WORDS 256
`define SOC_IO_BASE 32'h5000_0000
`define SOC_IO_SIZE 16

// Cycles of request without ready before a fault
`define SOC_BUS_TIMEOUT 16

// Board I/O
`define SOC_LED_W 10
`define SOC_KEY_W 4

`endif
